// ==== irCapturePkg.sv ====
`default_nettype none

package irCapturePkg;

    //////////////////////////////////////////////////////////////////////
    // Bus widths.
    //////////////////////////////////////////////////////////////////////
    localparam int ByteW = 8;               // Sensor parallel data width.
    localparam int WordW = 2 * ByteW;       // RAM word, two pixel bytes.
    localparam int AddrW = 14;              // RAM address width.

    //////////////////////////////////////////////////////////////////////
    // Frame geometry. Full sensor is 512 words by 192 lines.
    //////////////////////////////////////////////////////////////////////
    localparam int LineWords = 16;          // Words written per line.
    localparam int FrameLines = 4;          // Lines per frame.
    localparam int LineCntW = $clog2(FrameLines); // Line counter width.

    // Sync header prefix, always FF 00 00 before the tag byte.
    localparam logic [ByteW-1:0] SyncByte0 = 8'hFF;
    localparam logic [ByteW-1:0] SyncByte1 = 8'h00;
    localparam logic [ByteW-1:0] SyncByte2 = 8'h00;

    // Tag byte that closes each header.
    typedef enum logic [ByteW-1:0] {
        FrameTagA = 8'hB6,                  // First frame header.
        FrameTagB = 8'hAB,                  // Second frame header.
        LineTagA  = 8'h9D,                  // First line header.
        LineTagB  = 8'h80                   // Second line header, pixels follow.
    } headerTagT;

    // Capture FSM states.
    typedef enum logic [2:0] {
        WaitRamInit,                        // Hold until RAM init is done.
        SeekFrameA,
        SeekFrameB,
        SeekLineA,
        SeekLineB,
        CaptureLine,                        // Pixel bytes go to the RAM writer.
        LineEnd,                            // Count the finished line.
        FrameEnd
    } captureStateT;

endpackage

`default_nettype wire

// ==== pixelClkSync.sv ====
`timescale 1ns/1ps
`default_nettype none

module pixelClkSync import irCapturePkg::*; (
    input  wire              iClk,
    input  wire              iRst_N,
    input  wire              iEn,        // Low stops byte sampling.
    input  wire              iIrPclk,    // Sensor pixel clock, asynchronous.
    input  wire [ByteW-1:0]  iIrData,    // Sensor data, stable at pclk rise.
    output logic             byteValid,  // One-cycle strobe per sampled byte.
    output logic [ByteW-1:0] byteData
);

    logic [1:0]       pclkSync;          // Two-flop synchronizer chain.
    logic             pclkPrev;          // Last synchronized level.
    logic [ByteW-1:0] dataSync0;
    logic [ByteW-1:0] dataSync1;
    logic             pclkRise;

    // Pixel clock into the system domain.
    always_ff @(posedge iClk or negedge iRst_N) begin
        if (!iRst_N) begin
            pclkSync <= 2'b00;
            pclkPrev <= 1'b0;
        end else begin
            pclkSync <= {pclkSync[0], iIrPclk};
            pclkPrev <= pclkSync[1];
        end
    end

    // Data bits take the same two stages, so they line up with the edge.
    always_ff @(posedge iClk) begin
        dataSync0 <= iIrData;
        dataSync1 <= dataSync0;
    end

    assign pclkRise = pclkSync[1] && !pclkPrev; // Rising edge seen.

    // Sample one byte per edge, strobe lands on the third iClk edge.
    always_ff @(posedge iClk or negedge iRst_N) begin
        if (!iRst_N) begin
            byteValid <= 1'b0;
            byteData  <= '0;
        end else begin
            byteValid <= pclkRise && iEn;
            if (pclkRise && iEn) begin
                byteData <= dataSync1;   // Latch the synchronized byte.
            end
        end
    end

endmodule

`default_nettype wire

// ==== headerMatcher.sv ====
`timescale 1ns/1ps
`default_nettype none

module headerMatcher import irCapturePkg::*; (
    input  wire             iClk,
    input  wire             iRst_N,
    input  wire             byteValid,
    input  wire [ByteW-1:0] byteData,
    input  wire headerTagT  expectTag,   // Tag the controller is looking for.
    output logic            headerHit    // Current byte closes the header.
);

    // Last three bytes, histOld is the earliest.
    logic [ByteW-1:0] histOld;
    logic [ByteW-1:0] histMid;
    logic [ByteW-1:0] histNew;
    logic             prefixOk;

    always_ff @(posedge iClk or negedge iRst_N) begin
        if (!iRst_N) begin
            histOld <= '0;
            histMid <= '0;
            histNew <= '0;
        end else if (byteValid) begin
            histOld <= histMid;          // Shift one byte along.
            histMid <= histNew;
            histNew <= byteData;
        end
    end

    // FF 00 00 already seen.
    assign prefixOk = (histOld == SyncByte0) && (histMid == SyncByte1)
                   && (histNew == SyncByte2);

    assign headerHit = byteValid && prefixOk && (byteData == expectTag);

    //////////////////////////////////////////////////////////////////////
    // Checks.
    //////////////////////////////////////////////////////////////////////

    // A hit sits on a single-cycle byte strobe from the input stage.
    assert property (@(posedge iClk) disable iff (!iRst_N)
        headerHit |-> byteValid && !$past(byteValid))
        else $error("headerHit without a fresh byte strobe");

endmodule

`default_nettype wire

// ==== captureControl.sv ====
`timescale 1ns/1ps
`default_nettype none

module captureControl import irCapturePkg::*; (
    input  wire        iClk,
    input  wire        iRst_N,
    input  wire        iRamInitDone,     // Level from the RAM initializer.
    input  wire        headerHit,
    input  wire        lineFull,         // Writer finished the line.
    output headerTagT  expectTag,
    output logic       captureEn,        // Pixel bytes go to the RAM.
    output logic       oCapFrameStart,
    output logic       oCapLineDone,
    output logic       oCapFrameDone
);

    captureStateT        state;
    logic [LineCntW-1:0] lineCnt;        // Lines finished in this frame.

    // Tag to seek follows the state.
    always_comb begin
        case (state)
            SeekFrameB: expectTag = FrameTagB;
            SeekLineA:  expectTag = LineTagA;
            SeekLineB:  expectTag = LineTagB;
            default:    expectTag = FrameTagA;
        endcase
    end

    assign captureEn = (state == CaptureLine);

    //////////////////////////////////////////////////////////////////////
    // Frame and line FSM.
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge iClk or negedge iRst_N) begin
        if (!iRst_N) begin
            state          <= WaitRamInit;
            lineCnt        <= '0;
            oCapFrameStart <= 1'b0;
            oCapLineDone   <= 1'b0;
            oCapFrameDone  <= 1'b0;
        end else begin
            oCapFrameStart <= 1'b0;      // Pulses last one cycle.
            oCapLineDone   <= 1'b0;
            oCapFrameDone  <= 1'b0;
            case (state)
                WaitRamInit: begin
                    if (iRamInitDone) state <= SeekFrameA;
                end
                SeekFrameA: begin
                    if (headerHit) begin
                        state          <= SeekFrameB;
                        oCapFrameStart <= 1'b1; // New frame begins.
                        lineCnt        <= '0;
                    end
                end
                SeekFrameB: begin
                    if (headerHit) state <= SeekLineA;
                end
                SeekLineA: begin
                    if (headerHit) state <= SeekLineB;
                end
                SeekLineB: begin
                    if (headerHit) state <= CaptureLine; // Pixels follow.
                end
                CaptureLine: begin
                    if (lineFull) begin
                        state        <= LineEnd;
                        oCapLineDone <= 1'b1;
                    end
                end
                LineEnd: begin
                    if (lineCnt == LineCntW'(FrameLines - 1)) begin
                        state         <= FrameEnd;
                        oCapFrameDone <= 1'b1; // Last line of the frame.
                        lineCnt       <= '0;
                    end else begin
                        state   <= SeekLineA;
                        lineCnt <= lineCnt + 1'b1;
                    end
                end
                FrameEnd: state <= SeekFrameA; // Wait for the next frame.
                default:  state <= WaitRamInit;
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Checks.
    //////////////////////////////////////////////////////////////////////

    // The writer only closes a line that is being captured.
    assert property (@(posedge iClk) disable iff (!iRst_N)
        lineFull |-> captureEn)
        else $error("lineFull outside a captured line");

endmodule

`default_nettype wire

// ==== ramWriter.sv ====
`timescale 1ns/1ps
`default_nettype none

module ramWriter import irCapturePkg::*; (
    input  wire              iClk,
    input  wire              iRst_N,
    input  wire              byteValid,
    input  wire [ByteW-1:0]  byteData,
    input  wire              captureEn,  // Accept bytes only while high.
    output logic             oWrWhich,   // Selects RAM 0 or RAM 1.
    output logic [AddrW-1:0] oWrAddr,
    output logic [WordW-1:0] oWrData,
    output logic             oWrEn,
    output logic             lineFull    // One-cycle pulse at line end.
);

    logic             bytePhase;         // High while the first byte is held.
    logic [ByteW-1:0] hiByte;            // First byte of the pair.
    logic             byteTake;

    assign byteTake = byteValid && captureEn;

    // First byte of each pair.
    always_ff @(posedge iClk) begin
        if (byteTake && !bytePhase) begin
            hiByte <= byteData;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Word assembly and RAM write port.
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge iClk or negedge iRst_N) begin
        if (!iRst_N) begin
            bytePhase <= 1'b0;
            oWrWhich  <= 1'b0;           // First line goes to RAM 0.
            oWrAddr   <= '0;
            oWrData   <= '0;
            oWrEn     <= 1'b0;
            lineFull  <= 1'b0;
        end else begin
            oWrEn    <= 1'b0;
            lineFull <= 1'b0;
            if (!captureEn) begin
                bytePhase <= 1'b0;       // Each line starts on a pair boundary.
            end else if (byteValid) begin
                bytePhase <= !bytePhase;
            end
            if (byteTake && bytePhase) begin
                oWrEn   <= 1'b1;
                oWrData <= {hiByte, byteData}; // First byte high.
            end
            // Address moves on after each write.
            if (oWrEn) begin
                if (oWrAddr == AddrW'(LineWords - 1)) begin
                    oWrAddr  <= '0;
                    oWrWhich <= !oWrWhich; // Next line to the other RAM.
                    lineFull <= 1'b1;
                end else begin
                    oWrAddr <= oWrAddr + 1'b1;
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Checks.
    //////////////////////////////////////////////////////////////////////

    // Writes land only while the controller holds the line open.
    assert property (@(posedge iClk) disable iff (!iRst_N)
        oWrEn |-> captureEn)
        else $error("oWrEn while captureEn is low");

endmodule

`default_nettype wire

// ==== irCapture.sv ====
`timescale 1ns/1ps
`default_nettype none

module irCapture import irCapturePkg::*; (
    input  wire              iClk,
    input  wire              iRst_N,
    input  wire              iEn,
    input  wire              iIrPclk,
    input  wire [ByteW-1:0]  iIrData,
    input  wire              iRamInitDone,
    output logic             oCapFrameStart,
    output logic             oCapFrameDone,
    output logic             oCapLineDone,
    output logic             oWrWhich,
    output logic [AddrW-1:0] oWrAddr,
    output logic [WordW-1:0] oWrData,
    output logic             oWrEn
);

    logic             byteValid;         // Sampled byte strobe.
    logic [ByteW-1:0] byteData;
    headerTagT        expectTag;
    logic             headerHit;
    logic             captureEn;
    logic             lineFull;

    pixelClkSync i_pixelClkSync (
        .iClk      (iClk),
        .iRst_N    (iRst_N),
        .iEn       (iEn),
        .iIrPclk   (iIrPclk),
        .iIrData   (iIrData),
        .byteValid (byteValid),
        .byteData  (byteData)
    );

    headerMatcher i_headerMatcher (
        .iClk      (iClk),
        .iRst_N    (iRst_N),
        .byteValid (byteValid),
        .byteData  (byteData),
        .expectTag (expectTag),
        .headerHit (headerHit)
    );

    captureControl i_captureControl (
        .iClk           (iClk),
        .iRst_N         (iRst_N),
        .iRamInitDone   (iRamInitDone),
        .headerHit      (headerHit),
        .lineFull       (lineFull),
        .expectTag      (expectTag),
        .captureEn      (captureEn),
        .oCapFrameStart (oCapFrameStart),
        .oCapLineDone   (oCapLineDone),
        .oCapFrameDone  (oCapFrameDone)
    );

    ramWriter i_ramWriter (
        .iClk      (iClk),
        .iRst_N    (iRst_N),
        .byteValid (byteValid),
        .byteData  (byteData),
        .captureEn (captureEn),
        .oWrWhich  (oWrWhich),
        .oWrAddr   (oWrAddr),
        .oWrData   (oWrData),
        .oWrEn     (oWrEn),
        .lineFull  (lineFull)
    );

endmodule

`default_nettype wire

// ==== tbIrCapture.sv ====
`timescale 1ns/1ps
`default_nettype none

module tbIrCapture import irCapturePkg::*; ();

    localparam int ClkPeriod  = 40;
    localparam int DriveDelay = 2;          // Inputs move this long after the edge.
    localparam int Seed       = 32'h6f04_ddea;
    localparam int JunkBytes  = 12;         // Noise ahead of each frame header.
    localparam int GapAt      = 7;          // Pixel index where iEn drops.
    localparam int GapLen     = 5;          // Bytes lost while iEn is low.
    localparam int FrameBytes = JunkBytes + 8 + FrameLines * (8 + 2 * LineWords);
    localparam int WatchdogCycles = (3 * FrameBytes + GapLen) * 8 * 2;

    logic             iClk = 1'b0;
    logic             iRst_N;
    logic             iEn;
    logic             iIrPclk;
    logic [ByteW-1:0] iIrData;
    logic             iRamInitDone;
    logic             oCapFrameStart;
    logic             oCapFrameDone;
    logic             oCapLineDone;
    logic             oWrWhich;
    logic [AddrW-1:0] oWrAddr;
    logic [WordW-1:0] oWrData;
    logic             oWrEn;

    logic [WordW-1:0] expQ[$];              // Words the sensor model expects.
    logic [WordW-1:0] expWord;
    logic [ByteW-1:0] pendByte;             // First byte of an open pair.
    logic             pendValid = 1'b0;
    logic             prevWhich;
    int errCount = 0;
    int testErrBase = 0;
    int testCount = 0;
    int failCount = 0;
    int frameHdrCnt = 0;                    // Headers sent by the model.
    int lineHdrCnt = 0;
    int frameStartCnt = 0;                  // Pulses seen on the DUT outputs.
    int lineDoneCnt = 0;
    int frameDoneCnt = 0;
    int flipCnt = 0;
    int wordIdx = 0;                        // Expected address of the next write.

    irCapture i_irCapture (
        .iClk           (iClk),
        .iRst_N         (iRst_N),
        .iEn            (iEn),
        .iIrPclk        (iIrPclk),
        .iIrData        (iIrData),
        .iRamInitDone   (iRamInitDone),
        .oCapFrameStart (oCapFrameStart),
        .oCapFrameDone  (oCapFrameDone),
        .oCapLineDone   (oCapLineDone),
        .oWrWhich       (oWrWhich),
        .oWrAddr        (oWrAddr),
        .oWrData        (oWrData),
        .oWrEn          (oWrEn)
    );

    always #(ClkPeriod / 2) iClk = ~iClk;

    function automatic void noteFailure(input string what);
        $display("Check failed at %0t ns: %s", $time, what);
        errCount++;
    endfunction

    function automatic void valueError(input string sigName, input int expVal, input int actVal);
        $display("** Error at %0t ns: %s expected 0x%0h, got 0x%0h", $time, sigName, expVal,
                 actVal);
        errCount++;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Output monitor and write checker.
    //////////////////////////////////////////////////////////////////////
    always @(posedge iClk) begin
        if (iRst_N) begin
            if (oWrEn) begin
                if (expQ.size() == 0) begin
                    noteFailure("RAM write with no expected word left");
                end else begin
                    expWord = expQ.pop_front();
                    assert (oWrData == expWord)
                        else valueError("oWrData", int'(expWord), int'(oWrData));
                end
                assert (oWrAddr == AddrW'(wordIdx))
                    else valueError("oWrAddr", wordIdx, int'(oWrAddr));
                wordIdx <= (wordIdx == LineWords - 1) ? 0 : wordIdx + 1; // Restart per line.
            end
            if (oWrWhich != prevWhich) flipCnt <= flipCnt + 1;
            if (oCapFrameStart) frameStartCnt <= frameStartCnt + 1;
            if (oCapLineDone) lineDoneCnt <= lineDoneCnt + 1;
            if (oCapFrameDone) frameDoneCnt <= frameDoneCnt + 1;
        end
        prevWhich <= oWrWhich;
    end

    // Frame start only answers a FrameTagA header.
    assert property (@(posedge iClk) disable iff (!iRst_N)
        oCapFrameStart |-> frameStartCnt < frameHdrCnt)
        else noteFailure("oCapFrameStart without a new FrameTagA header");

    // Writes only between a LineTagB header and the RAM flip.
    assert property (@(posedge iClk) disable iff (!iRst_N)
        oWrEn |-> lineHdrCnt > flipCnt)
        else noteFailure("RAM write outside an open line");

    assert property (@(posedge iClk) disable iff (!iRst_N)
        (oCapLineDone || oCapFrameDone) |-> frameStartCnt > 0)
        else noteFailure("line or frame pulse before any frame start");

    // Line done follows the RAM select flip by one cycle.
    assert property (@(posedge iClk) disable iff (!iRst_N)
        oCapLineDone |-> $past(oWrWhich) != $past(oWrWhich, 2))
        else noteFailure("oCapLineDone without a preceding oWrWhich flip");

    assert property (@(posedge iClk) disable iff (!iRst_N)
        $changed(oWrWhich) |-> $past(oWrEn) && ($past(oWrAddr) == AddrW'(LineWords - 1))
            && (oWrAddr == '0))
        else noteFailure("oWrWhich flipped away from the last word of a line");

    assert property (@(posedge iClk) disable iff (!iRst_N)
        oCapFrameDone |-> $past(oCapLineDone)
            && (lineDoneCnt == (frameDoneCnt + 1) * FrameLines))
        else noteFailure("oCapFrameDone out of step with the line count");

    assert property (@(posedge iClk) disable iff (!iRst_N)
        (!iEn && !$past(iEn)) |-> !oWrEn)
        else noteFailure("RAM write while iEn is low");

    //////////////////////////////////////////////////////////////////////
    // Sensor model.
    //////////////////////////////////////////////////////////////////////
    function automatic logic [ByteW-1:0] randomPixel();
        return ByteW'($urandom_range(254, 0)); // Never FF, so no stray sync prefix.
    endfunction

    // One byte per 8 cycles, pclk rises mid-slot.
    task automatic sendByte(input logic [ByteW-1:0] b, input logic en);
        iIrData = b;
        iIrPclk = 1'b0;
        iEn     = en;
        repeat (4) @(posedge iClk);
        #DriveDelay iIrPclk = 1'b1;
        repeat (4) @(posedge iClk);
        #DriveDelay;
    endtask

    // Pair sampled bytes, first one high.
    task automatic recordByte(input logic [ByteW-1:0] b);
        if (pendValid) begin
            expQ.push_back({pendByte, b});
            pendValid = 1'b0;
        end else begin
            pendByte  = b;
            pendValid = 1'b1;
        end
    endtask

    task automatic sendHeader(input headerTagT tag);
        sendByte(SyncByte0, 1'b1);
        sendByte(SyncByte1, 1'b1);
        sendByte(SyncByte2, 1'b1);
        if (tag == FrameTagA) frameHdrCnt++;
        if (tag == LineTagB) lineHdrCnt++;  // Line opens with this tag.
        sendByte(tag, 1'b1);
    endtask

    task automatic sendFrameHead();
        for (int i = 0; i < JunkBytes; i++) begin
            sendByte(randomPixel(), 1'b1);
        end
        sendHeader(FrameTagA);
        sendHeader(FrameTagB);
    endtask

    // Extra bytes make up for the ones lost in the iEn gap.
    task automatic sendLine(input int gapLen);
        logic [ByteW-1:0] b;
        logic             en;
        sendHeader(LineTagA);
        sendHeader(LineTagB);
        for (int i = 0; i < 2 * LineWords + gapLen; i++) begin
            b  = randomPixel();
            en = !(i >= GapAt && i < GapAt + gapLen);
            if (en) recordByte(b);
            sendByte(b, en);
        end
    endtask

    task automatic sendFrame(input int gapLine);
        for (int l = 0; l < FrameLines; l++) begin
            sendLine((l == gapLine) ? GapLen : 0);
        end
    endtask

    task automatic waitFrameDone(input int target);
        int n;
        n = 0;
        while (frameDoneCnt < target && n < 64) begin
            @(posedge iClk);
            #DriveDelay;
            n++;
        end
        if (frameDoneCnt < target) noteFailure("oCapFrameDone never arrived");
    endtask

    task automatic endTest(input string name, input int frames, input int lines,
                           input int dones);
        int testErr;
        assert (frameStartCnt == frames)
            else valueError("oCapFrameStart count", frames, frameStartCnt);
        assert (lineDoneCnt == lines) else valueError("oCapLineDone count", lines, lineDoneCnt);
        assert (flipCnt == lines) else valueError("oWrWhich flip count", lines, flipCnt);
        assert (frameDoneCnt == dones) else valueError("oCapFrameDone count", dones, frameDoneCnt);
        assert (oWrWhich == 1'(lines % 2)) else valueError("oWrWhich", lines % 2, int'(oWrWhich));
        assert (expQ.size() == 0) else noteFailure("expected words were never written");
        testCount++;
        testErr = errCount - testErrBase;
        testErrBase = errCount;
        if (testErr == 0) begin
            $display("Test %0d %s: ok", testCount, name);
        end else begin
            failCount++;
            $display("Test %0d %s: %0d errors", testCount, name, testErr);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Test sequence.
    //////////////////////////////////////////////////////////////////////
    initial begin
        void'($urandom(Seed));
        iRst_N       = 1'b0;
        iEn          = 1'b1;
        iIrPclk      = 1'b0;
        iIrData      = '0;
        iRamInitDone = 1'b0;
        repeat (16) @(posedge iClk);
        #DriveDelay iRst_N = 1'b1;
        fork
            begin
                repeat (10) @(posedge iClk);
                #DriveDelay iRamInitDone = 1'b1; // Rises during the junk bytes.
            end
            sendFrameHead();
        join
        endTest("frame start", 1, 0, 0);
        sendFrame(-1);
        waitFrameDone(1);
        endTest("first frame", 1, FrameLines, 1);
        sendFrameHead();
        sendFrame(-1);
        waitFrameDone(2);
        endTest("second frame", 2, 2 * FrameLines, 2);
        sendFrameHead();
        sendFrame(1);                       // iEn gap inside line 1.
        waitFrameDone(3);
        endTest("enable gap", 3, 3 * FrameLines, 3);
        $display("Summary: %0d tests, %0d failed, %0d errors", testCount, failCount, errCount);
        if (failCount == 0 && errCount == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // Watchdog, twice the full byte stream.
    initial begin
        repeat (WatchdogCycles) @(posedge iClk);
        $display("Watchdog expired after %0d cycles, capture never finished", WatchdogCycles);
        $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
irCapturePkg.sv
pixelClkSync.sv
headerMatcher.sv
captureControl.sv
ramWriter.sv
irCapture.sv
tbIrCapture.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tbIrCapture
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= test passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
